// ==== flist.f ====
+incdir+include
verilog/rvc_pkg.sv
verilog/rvc_parcel_assembler.sv
verilog/rvc_expander.sv
verilog/rvc_op_classifier.sv
verilog/rvc_csr_block.sv
verilog/rvc_frontend.sv
verif/rvc_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it, exit status is the result
verilator --binary \
    -f flist.f \
    --top-module rvc_frontend_tb \
    -Mdir obj_dir \
    -o rvc_sim \
    && ./obj_dir/rvc_sim \
    || { echo "simulation did not complete cleanly"; exit 1; }

// ==== verif/rvc_frontend_tb.sv ====
`timescale 1ns/1ps

module rvc_frontend_tb
    import rvc_pkg::*;
();

    typedef struct {
        string       name;
        logic [15:0] p0;
        logic [15:0] p1;
        int          np;        // parcels in the instruction
        bit          flush;     // lone low half and flush first
        bit          c_en;      // enable bit while this entry runs
        bit          no_gap;    // straight after the previous entry
        logic [31:0] exp_instr;
        op_class_e   exp_class;
        bit          exp_c;
        bit          exp_ill;
    } entry_t;

    logic        clk;
    logic        reset_i;
    logic        parcel_valid_i;
    logic [15:0] parcel_i;
    logic        flush_i;
    logic        cfg_we_i;
    cfg_addr_e   cfg_addr_i;
    logic [31:0] cfg_wdata_i;
    logic [31:0] cfg_rdata_o;
    logic        instr_valid_o;
    logic [31:0] instr_o;
    logic        is_compressed_o;
    op_class_e   op_class_o;
    logic        illegal_o;

    entry_t tbl[$];
    int     pend_idx[$];   // entries still in flight
    int     pend_cyc[$];   // cycle their strobe is due
    int     cycle;
    int     limit;
    int     checked;
    int     seed;
    int     n_comp;
    bit     cur_en;
    entry_t cur;
    int     got_idx;
    int     got_cyc;
    int     rnd;

    rvc_frontend i_dut (
        .clk_i           (clk),
        .reset_i         (reset_i),
        .parcel_valid_i  (parcel_valid_i),
        .parcel_i        (parcel_i),
        .flush_i         (flush_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o),
        .instr_valid_o   (instr_valid_o),
        .instr_o         (instr_o),
        .is_compressed_o (is_compressed_o),
        .op_class_o      (op_class_o),
        .illegal_o       (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_instr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "instruction word wrong");
        end
    endtask

    task automatic check_class(input string name, input op_class_e exp, input op_class_e act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %s actual %s", name, exp.name(), act.name());
            $display("Checks failed");
            $fatal(1, "instruction class wrong");
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0b actual %0b", name, exp, act);
            $display("Checks failed");
            $fatal(1, "flag wrong");
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            $display("Checks failed");
            $fatal(1, "count wrong");
        end
    endtask

    // ----------------------------------------------------------------------
    // table building
    // ----------------------------------------------------------------------
    task automatic add_entry(input string name, input logic [15:0] p0, input logic [15:0] p1,
                             input int np, input bit flush, input bit c_en, input bit no_gap,
                             input logic [31:0] ei, input op_class_e ec, input bit ecmp,
                             input bit eill);
        entry_t t;
        t.name = name;
        t.p0 = p0;
        t.p1 = p1;
        t.np = np;
        t.flush = flush;
        t.c_en = c_en;
        t.no_gap = no_gap;
        t.exp_instr = ei;
        t.exp_class = ec;
        t.exp_c = ecmp;
        t.exp_ill = eill;
        tbl.push_back(t);
    endtask

    task automatic add_c(input string name, input logic [15:0] p, input logic [31:0] ei,
                         input op_class_e ec);
        add_entry(name, p, 16'h0, 1, 1'b0, 1'b1, 1'b0, ei, ec, 1'b1, 1'b0);
    endtask

    task automatic add_ill(input string name, input logic [15:0] p);
        add_entry(name, p, 16'h0, 1, 1'b0, 1'b1, 1'b0, 32'h0000_0013, OPC_ILLEGAL, 1'b1, 1'b1);
    endtask

    task automatic add_w(input string name, input logic [31:0] w, input op_class_e ec);
        add_entry(name, w[15:0], w[31:16], 2, 1'b0, 1'b1, 1'b0, w, ec, 1'b0, 1'b0);
    endtask

    task automatic drive_parcel(input logic [15:0] p);
        @(negedge clk);
        parcel_valid_i = 1'b1;
        parcel_i = p;
        flush_i = 1'b0;
        cfg_we_i = 1'b0;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        rnd = $random(seed);
        parcel_valid_i = 1'b0;
        parcel_i = rnd[15:0];  // junk while idle
        flush_i = 1'b0;
        cfg_we_i = 1'b0;
    endtask

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= limit) begin
            $display("Checks failed");
            $fatal(1, "timeout after %0d cycles", cycle);
        end
    end

    // one expected entry per output strobe
    always @(negedge clk) begin
        if (!reset_i && instr_valid_o) begin
            if (pend_idx.size() == 0) begin
                $display("instr_valid_o went high with no instruction outstanding");
                $display("Checks failed");
                $fatal(1, "unexpected output strobe");
            end else begin
                got_idx = pend_idx.pop_front();
                got_cyc = pend_cyc.pop_front();
                cur = tbl[got_idx];
                check_count({cur.name, " latency"}, got_cyc, cycle);
                check_instr(cur.name, cur.exp_instr, instr_o);
                check_class(cur.name, cur.exp_class, op_class_o);
                check_flag({cur.name, " compressed"}, cur.exp_c, is_compressed_o);
                check_flag({cur.name, " illegal"}, cur.exp_ill, illegal_o);
                checked = checked + 1;
            end
        end
    end

    initial begin
        entry_t t;
        int     parcels;
        reset_i = 1'b1;
        parcel_valid_i = 1'b0;
        parcel_i = 16'h0;
        flush_i = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = CFG_CTRL;
        cfg_wdata_i = 32'h0;
        cycle = 0;
        checked = 0;
        seed = 32'h63ea_f6d9;
        cur_en = 1'b1;
        n_comp = 0;
        parcels = 0;

        // supported compressed forms
        add_c("c.addi4spn", 16'h0040, 32'h0041_0413, OPC_OP_IMM);
        add_c("c.lw",       16'h4144, 32'h0045_2483, OPC_LOAD);
        add_c("c.sw",       16'hC504, 32'h0095_2423, OPC_STORE);
        add_c("c.swsp",     16'hC616, 32'h0051_2623, OPC_STORE);
        add_c("c.lwsp",     16'h4322, 32'h0081_2303, OPC_LOAD);
        add_c("c.j",        16'hA021, 32'h0080_006F, OPC_JAL);
        add_c("c.jal",      16'h2021, 32'h0080_00EF, OPC_JAL);
        add_c("c.beqz",     16'hC011, 32'h0004_0263, OPC_BRANCH);
        add_c("c.bnez",     16'hE011, 32'h0004_1263, OPC_BRANCH);
        add_c("c.addi",     16'h028D, 32'h0032_8293, OPC_OP_IMM);
        add_c("c.nop",      16'h0001, 32'h0000_0013, OPC_OP_IMM);
        add_c("c.li",       16'h557D, 32'hFFF0_0513, OPC_OP_IMM);
        add_c("c.lui",      16'h6385, 32'h0000_13B7, OPC_LUI);
        add_c("c.addi16sp", 16'h6141, 32'h0101_0113, OPC_OP_IMM);
        add_c("c.slli",     16'h058A, 32'h0025_9593, OPC_OP_IMM);
        add_c("c.srli",     16'h808D, 32'h0034_D493, OPC_OP_IMM);
        add_c("c.srai",     16'h848D, 32'h4034_D493, OPC_OP_IMM);
        add_c("c.andi",     16'h98F9, 32'hFFE4_F493, OPC_OP_IMM);
        add_c("c.sub",      16'h8C05, 32'h4094_0433, OPC_OP);
        add_c("c.xor",      16'h8C25, 32'h0094_4433, OPC_OP);
        add_c("c.or",       16'h8C45, 32'h0094_6433, OPC_OP);
        add_c("c.and",      16'h8C65, 32'h0094_7433, OPC_OP);
        add_c("c.jr",       16'h8082, 32'h0000_8067, OPC_JALR);
        add_c("c.mv",       16'h852E, 32'h00B0_0533, OPC_OP);
        add_c("c.jalr",     16'h9282, 32'h0002_80E7, OPC_JALR);
        add_c("c.add",      16'h952E, 32'h00B5_0533, OPC_OP);
        // 32-bit pass through followed by compressed back to back
        add_w("addi x1", 32'h0050_0093, OPC_OP_IMM);
        add_w("lw x2",   32'h0001_A103, OPC_LOAD);
        add_w("lui x5",  32'h1234_52B7, OPC_LUI);
        add_entry("b2b c.or", 16'h8C45, 16'h0, 1, 1'b0, 1'b1, 1'b1,
                  32'h0094_6433, OPC_OP, 1'b1, 1'b0);
        add_entry("b2b c.li", 16'h557D, 16'h0, 1, 1'b0, 1'b1, 1'b1,
                  32'hFFF0_0513, OPC_OP_IMM, 1'b1, 1'b0);
        // reserved encodings
        add_ill("zero parcel",    16'h0000);
        add_ill("addi4spn imm 0", 16'h0004);
        add_ill("lwsp rd 0",      16'h4002);
        add_ill("jr rs1 0",       16'h8002);
        add_ill("lui imm 0",      16'h6381);
        add_ill("addi16sp imm 0", 16'h6101);
        add_ill("subw slot",      16'h9C01);
        add_ill("c.fld",          16'h2000);
        add_ill("c.flwsp",        16'h6002);
        // extension switched off and back on
        add_entry("off c.addi", 16'h028D, 16'h0, 1, 1'b0, 1'b0, 1'b0,
                  32'h0032_8293, OPC_ILLEGAL, 1'b1, 1'b1);
        add_entry("off addi x1", 16'h0093, 16'h0050, 2, 1'b0, 1'b0, 1'b0,
                  32'h0050_0093, OPC_OP_IMM, 1'b0, 1'b0);
        add_c("on c.nop", 16'h0001, 32'h0000_0013, OPC_OP_IMM);
        // flush drops a lone low half
        add_entry("flush c.mv", 16'h852E, 16'h0, 1, 1'b1, 1'b1, 1'b0,
                  32'h00B0_0533, OPC_OP, 1'b1, 1'b0);
        add_entry("flush lw x2", 16'hA103, 16'h0001, 2, 1'b1, 1'b1, 1'b0,
                  32'h0001_A103, OPC_LOAD, 1'b0, 1'b0);

        foreach (tbl[i]) begin
            parcels = parcels + tbl[i].np + (tbl[i].flush ? 1 : 0);
            if (tbl[i].exp_c) begin
                n_comp = n_comp + 1;
            end
        end
        limit = 4 * parcels + 50;

        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        foreach (tbl[i]) begin
            t = tbl[i];
            if (t.c_en != cur_en) begin
                @(negedge clk);
                parcel_valid_i = 1'b0;
                cfg_we_i = 1'b1;
                cfg_addr_i = CFG_CTRL;
                cfg_wdata_i = {31'd0, t.c_en};
                cur_en = t.c_en;
            end
            rnd = $random(seed);
            if (!t.no_gap && rnd[0]) begin
                drive_idle();
            end
            if (t.flush) begin
                drive_parcel(16'h0013);  // low half only
                drive_idle();
                flush_i = 1'b1;
            end
            drive_parcel(t.p0);
            if (t.np == 2) begin
                drive_parcel(t.p1);
            end
            pend_idx.push_back(i);
            pend_cyc.push_back(cycle + 2);  // strobe two cycles after the last parcel
        end
        drive_idle();

        while (checked < tbl.size()) begin
            @(negedge clk);
        end
        @(negedge clk);
        cfg_addr_i = CFG_CNT_ALL;
        #1;
        check_count("total count", tbl.size(), cfg_rdata_o);
        cfg_addr_i = CFG_CNT_C;
        #1;
        check_count("compressed count", n_comp, cfg_rdata_o);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verilog/rvc_frontend.sv ====
`timescale 1ns/1ps

module rvc_frontend
    import rvc_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        parcel_valid_i,
    input  logic [15:0] parcel_i,
    input  logic        flush_i,
    input  logic        cfg_we_i,
    input  cfg_addr_e   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    output logic        instr_valid_o,
    output logic [31:0] instr_o,
    output logic        is_compressed_o,
    output op_class_e   op_class_o,
    output logic        illegal_o
);

    logic        asm_valid;
    logic [31:0] asm_instr;
    logic [31:0] exp_instr;
    logic        exp_is_compressed;
    logic        exp_illegal;
    logic        c_enable;

    rvc_parcel_assembler i_assembler (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .parcel_valid_i (parcel_valid_i),
        .parcel_i       (parcel_i),
        .flush_i        (flush_i),
        .asm_valid_o    (asm_valid),
        .asm_instr_o    (asm_instr)
    );

    rvc_expander i_expander (
        .instr_i         (asm_instr),
        .instr_o         (exp_instr),
        .is_compressed_o (exp_is_compressed),
        .illegal_o       (exp_illegal)
    );

    rvc_op_classifier i_classifier (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .in_valid_i      (asm_valid),
        .instr_i         (exp_instr),
        .is_compressed_i (exp_is_compressed),
        .exp_illegal_i   (exp_illegal),
        .c_enable_i      (c_enable),
        .instr_valid_o   (instr_valid_o),
        .instr_o         (instr_o),
        .is_compressed_o (is_compressed_o),
        .op_class_o      (op_class_o),
        .illegal_o       (illegal_o)
    );

    // counters see the decoder strobe
    rvc_csr_block i_csr (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .cfg_we_i            (cfg_we_i),
        .cfg_addr_i          (cfg_addr_i),
        .cfg_wdata_i         (cfg_wdata_i),
        .cfg_rdata_o         (cfg_rdata_o),
        .retire_i            (instr_valid_o),
        .retire_compressed_i (is_compressed_o),
        .c_enable_o          (c_enable)
    );

endmodule

// ==== verilog/rvc_csr_block.sv ====
`timescale 1ns/1ps

`include "rvc_cfg.svh"

module rvc_csr_block
    import rvc_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        cfg_we_i,
    input  cfg_addr_e   cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    input  logic        retire_i,
    input  logic        retire_compressed_i,
    output logic        c_enable_o
);

    logic                  c_enable_q;
    logic [`RVC_CNT_W-1:0] cnt_c_q;
    logic [`RVC_CNT_W-1:0] cnt_all_q;

    // ---------------------------------------------------------------------
    // control register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            c_enable_q <= 1'b1;  // extension on out of reset
        end else if (cfg_we_i && (cfg_addr_i == CFG_CTRL)) begin
            c_enable_q <= cfg_wdata_i[0];
        end
    end

    // ---------------------------------------------------------------------
    // instruction counters, illegal ones included
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_c_q   <= '0;
            cnt_all_q <= '0;
        end else if (retire_i) begin
            cnt_all_q <= cnt_all_q + 1'b1;
            if (retire_compressed_i) begin
                cnt_c_q <= cnt_c_q + 1'b1;
            end
        end
    end

    // read side is combinational
    always_comb begin
        case (cfg_addr_i)
            CFG_CTRL:    cfg_rdata_o = {31'd0, c_enable_q};
            CFG_CNT_C:   cfg_rdata_o = 32'(cnt_c_q);
            CFG_CNT_ALL: cfg_rdata_o = 32'(cnt_all_q);
            default:     cfg_rdata_o = 32'd0;  // unmapped
        endcase
    end

    assign c_enable_o = c_enable_q;

endmodule

// ==== verilog/rvc_op_classifier.sv ====
`timescale 1ns/1ps

`include "rvc_cfg.svh"

module rvc_op_classifier
    import rvc_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        in_valid_i,
    input  logic [31:0] instr_i,
    input  logic        is_compressed_i,
    input  logic        exp_illegal_i,
    input  logic        c_enable_i,
    output logic        instr_valid_o,
    output logic [31:0] instr_o,
    output logic        is_compressed_o,
    output op_class_e   op_class_o,
    output logic        illegal_o
);

    op_class_e class_d;
    logic      illegal_d;

    // compressed forms are rejected while the extension is off
    assign illegal_d = exp_illegal_i | (is_compressed_i & ~c_enable_i);

    always_comb begin
        case (instr_i[6:0])
            `RV_OPC_LOAD:   class_d = OPC_LOAD;
            `RV_OPC_STORE:  class_d = OPC_STORE;
            `RV_OPC_BRANCH: class_d = OPC_BRANCH;
            `RV_OPC_JAL:    class_d = OPC_JAL;
            `RV_OPC_JALR:   class_d = OPC_JALR;
            `RV_OPC_OP_IMM: class_d = OPC_OP_IMM;
            `RV_OPC_OP:     class_d = OPC_OP;
            `RV_OPC_LUI:    class_d = OPC_LUI;
            default:        class_d = OPC_OTHER;
        endcase
        if (illegal_d) begin
            class_d = OPC_ILLEGAL;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= in_valid_i;
        end
    end

    // payload follows the strobe, bits pass unchanged
    always_ff @(posedge clk_i) begin
        instr_o         <= instr_i;
        is_compressed_o <= is_compressed_i;
        op_class_o      <= class_d;
        illegal_o       <= illegal_d;
    end

endmodule

// ==== verilog/rvc_expander.sv ====
`timescale 1ns/1ps

`include "rvc_cfg.svh"

module rvc_expander (
    input  logic [31:0] instr_i,
    output logic [31:0] instr_o,
    output logic        is_compressed_o,
    output logic        illegal_o
);

    // compressed opcode as {funct3, quadrant}
    typedef enum logic [4:0] {
        C_ADDI4SPN = 5'b000_00,
        C_LW       = 5'b010_00,
        C_SW       = 5'b110_00,
        C_ADDI     = 5'b000_01,
        C_JAL      = 5'b001_01,
        C_LI       = 5'b010_01,
        C_LUI      = 5'b011_01,  // also addi16sp
        C_ARITH    = 5'b100_01,
        C_J        = 5'b101_01,
        C_BEQZ     = 5'b110_01,
        C_BNEZ     = 5'b111_01,
        C_SLLI     = 5'b000_10,
        C_LWSP     = 5'b010_10,
        C_CR       = 5'b100_10,  // jr, mv, jalr, add, ebreak
        C_SWSP     = 5'b110_10
    } c_op_e;

    logic [15:0] c;
    logic [4:0]  rd;       // full register fields
    logic [4:0]  rs2;
    logic [4:0]  r_hi_p;   // x8..x15 from bits 9:7
    logic [4:0]  r_lo_p;   // x8..x15 from bits 4:2
    logic [2:0]  alu_f3;
    logic [31:0] exp_instr;
    logic        exp_ill;

    assign c      = instr_i[15:0];
    assign rd     = c[11:7];
    assign rs2    = c[6:2];
    assign r_hi_p = {2'b01, c[9:7]};
    assign r_lo_p = {2'b01, c[4:2]};

    always_comb begin
        exp_instr = `RVC_NOP;
        exp_ill   = 1'b0;
        alu_f3    = 3'b000;
        case ({c[15:13], c[1:0]})
            // -----------------------------------------------------------------
            // quadrant 0
            // -----------------------------------------------------------------
            C_ADDI4SPN: begin  // addi rd', x2, nzuimm
                exp_ill   = (c[12:5] == 8'h00);  // covers the all-zero parcel too
                exp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000,
                             r_lo_p, `RV_OPC_OP_IMM};
            end
            C_LW: begin
                exp_instr = {5'b00000, c[5], c[12:10], c[6], 2'b00, r_hi_p, 3'b010,
                             r_lo_p, `RV_OPC_LOAD};
            end
            C_SW: begin
                exp_instr = {5'b00000, c[5], c[12], r_lo_p, r_hi_p, 3'b010,
                             c[11:10], c[6], 2'b00, `RV_OPC_STORE};
            end
            // -----------------------------------------------------------------
            // quadrant 1
            // -----------------------------------------------------------------
            C_ADDI, C_LI: begin  // li reads x0 instead of rd
                exp_instr = {{7{c[12]}}, c[6:2], c[14] ? 5'd0 : rd, 3'b000, rd,
                             `RV_OPC_OP_IMM};
            end
            C_JAL, C_J: begin  // only the link register differs
                exp_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                             {9{c[12]}}, c[15] ? 5'd0 : 5'd1, `RV_OPC_JAL};
            end
            C_LUI: begin
                exp_ill = ({c[12], c[6:2]} == 6'd0);
                if (rd == 5'd2) begin  // addi16sp
                    exp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2,
                                 3'b000, 5'd2, `RV_OPC_OP_IMM};
                end else begin
                    exp_instr = {{15{c[12]}}, c[6:2], rd, `RV_OPC_LUI};
                end
            end
            C_ARITH: begin
                case (c[11:10])
                    2'b00: begin  // srli
                        exp_ill   = c[12];  // shamt[5] is rv64 only
                        exp_instr = {7'b0000000, c[6:2], r_hi_p, 3'b101, r_hi_p,
                                     `RV_OPC_OP_IMM};
                    end
                    2'b01: begin  // srai
                        exp_ill   = c[12];
                        exp_instr = {7'b0100000, c[6:2], r_hi_p, 3'b101, r_hi_p,
                                     `RV_OPC_OP_IMM};
                    end
                    2'b10: begin  // andi
                        exp_instr = {{7{c[12]}}, c[6:2], r_hi_p, 3'b111, r_hi_p,
                                     `RV_OPC_OP_IMM};
                    end
                    default: begin
                        exp_ill = c[12];  // subw, addw and reserved slots
                        case (c[6:5])
                            2'b00:   alu_f3 = 3'b000;  // sub
                            2'b01:   alu_f3 = 3'b100;  // xor
                            2'b10:   alu_f3 = 3'b110;  // or
                            default: alu_f3 = 3'b111;  // and
                        endcase
                        exp_instr = {1'b0, (c[6:5] == 2'b00), 5'b00000, r_lo_p, r_hi_p,
                                     alu_f3, r_hi_p, `RV_OPC_OP};
                    end
                endcase
            end
            C_BEQZ, C_BNEZ: begin  // funct3 bit 0 picks bne
                exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, r_hi_p, 2'b00, c[13],
                             c[11:10], c[4:3], c[12], `RV_OPC_BRANCH};
            end
            // -----------------------------------------------------------------
            // quadrant 2
            // -----------------------------------------------------------------
            C_SLLI: begin
                exp_ill   = c[12];
                exp_instr = {7'b0000000, c[6:2], rd, 3'b001, rd, `RV_OPC_OP_IMM};
            end
            C_LWSP: begin
                exp_ill   = (rd == 5'd0);
                exp_instr = {4'b0000, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, rd,
                             `RV_OPC_LOAD};
            end
            C_SWSP: begin
                exp_instr = {4'b0000, c[8:7], c[12], rs2, 5'd2, 3'b010, c[11:9], 2'b00,
                             `RV_OPC_STORE};
            end
            C_CR: begin
                if (rs2 != 5'd0) begin  // mv when bit 12 clear, add when set
                    exp_instr = {7'b0000000, rs2, c[12] ? rd : 5'd0, 3'b000, rd,
                                 `RV_OPC_OP};
                end else if (!c[12]) begin  // jr
                    exp_ill   = (rd == 5'd0);
                    exp_instr = {12'h000, rd, 3'b000, 5'd0, `RV_OPC_JALR};
                end else if (rd == 5'd0) begin
                    exp_instr = 32'h0010_0073;  // ebreak
                end else begin  // jalr
                    exp_instr = {12'h000, rd, 3'b000, 5'd1, `RV_OPC_JALR};
                end
            end
            default: begin
                exp_ill = 1'b1;  // fp loads and stores, reserved
            end
        endcase
    end

    assign is_compressed_o = (instr_i[1:0] != 2'b11);
    assign illegal_o       = is_compressed_o & exp_ill;
    assign instr_o         = !is_compressed_o ? instr_i :
                             exp_ill          ? `RVC_NOP : exp_instr;

endmodule

// ==== verilog/rvc_parcel_assembler.sv ====
`timescale 1ns/1ps

module rvc_parcel_assembler (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        parcel_valid_i,
    input  logic [15:0] parcel_i,
    input  logic        flush_i,
    output logic        asm_valid_o,
    output logic [31:0] asm_instr_o
);

    logic        pending_q;  // low half of a 32-bit instruction held
    logic [15:0] low_q;
    logic        valid_q;
    logic [31:0] instr_q;
    logic        is_full_parcel;

    // low bits 11 open a 32-bit instruction
    assign is_full_parcel = (parcel_i[1:0] == 2'b11);

    // ---------------------------------------------------------------------
    // control state
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            pending_q <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;  // one cycle strobe
            if (parcel_valid_i) begin
                if (pending_q) begin
                    pending_q <= 1'b0;
                    valid_q   <= 1'b1;
                end else if (is_full_parcel) begin
                    pending_q <= 1'b1;
                end else begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // payload
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (parcel_valid_i) begin
            if (pending_q) begin
                instr_q <= {parcel_i, low_q};  // upper half completes the pair
            end else if (is_full_parcel) begin
                low_q <= parcel_i;
            end else begin
                instr_q <= {16'h0000, parcel_i};
            end
        end
    end

    assign asm_valid_o = valid_q;
    assign asm_instr_o = instr_q;

endmodule

// ==== verilog/rvc_pkg.sv ====
`include "rvc_cfg.svh"

package rvc_pkg;

    // class tag handed to the decoder
    typedef enum logic [3:0] {
        OPC_LOAD,
        OPC_STORE,
        OPC_BRANCH,
        OPC_JAL,
        OPC_JALR,
        OPC_OP_IMM,
        OPC_OP,
        OPC_LUI,
        OPC_OTHER,
        OPC_ILLEGAL
    } op_class_e;

    // register port map
    typedef enum logic [1:0] {
        CFG_CTRL    = `RVC_ADDR_CTRL,     // bit 0 is the c-extension enable
        CFG_CNT_C   = `RVC_ADDR_CNT_C,    // compressed count, read only
        CFG_CNT_ALL = `RVC_ADDR_CNT_ALL   // total count, read only
    } cfg_addr_e;

endpackage

// ==== include/rvc_cfg.svh ====
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// ---------------------------------------------------------------------
// rv32i base opcodes, bits [6:0]
// ---------------------------------------------------------------------
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_OP      7'b0110011
`define RV_OPC_LUI     7'b0110111

// addi x0, x0, 0
`define RVC_NOP        32'h0000_0013

// instruction counter width
`define RVC_CNT_W      32

// ---------------------------------------------------------------------
// configuration register addresses
// ---------------------------------------------------------------------
`define RVC_ADDR_CTRL     2'd0
`define RVC_ADDR_CNT_C    2'd1
`define RVC_ADDR_CNT_ALL  2'd2

`endif
